//--- conv_sys.f
logic/conv_pkg.sv
logic/loop_counters.sv
logic/window_sequencer.sv
logic/window_mac.sv
logic/result_combiner.sv
logic/conv_sys_top.sv
tests/output_checker.sv
tests/tb_conv_sys.sv

//--- logic/conv_pkg.sv
package conv_pkg;

  // pixel and weight width, signed
  localparam int PIXEL_WIDTH = 16;
  // window side, also pixels per streamed row
  localparam int KERNEL_SIZE = 3;
  // dot product and combined output width
  localparam int ACC_WIDTH = 40;
  // width of x, y and channel tags
  localparam int COORD_WIDTH = 8;

  typedef logic signed [PIXEL_WIDTH-1:0] pixel_t;

  // one row of the window, element 0 is the leftmost pixel
  typedef pixel_t [KERNEL_SIZE-1:0] pixel_row_t;

  // per engine row write strobes, one bit per row slot
  typedef struct packed {
    logic [KERNEL_SIZE-1:0] wt_we;
    logic [KERNEL_SIZE-1:0] in_we;
  } load_ctrl_t;

  // output coordinate tag
  typedef struct packed {
    logic [COORD_WIDTH-1:0] x;
    logic [COORD_WIDTH-1:0] y;
    logic [COORD_WIDTH-1:0] ch;
  } coord_t;

  // tagged output pixel
  typedef struct packed {
    logic signed [ACC_WIDTH-1:0] value;
    coord_t                      pos;
  } conv_result_t;

  // stride select: 0 -> 1, 1 -> 2, 2 -> 4
  typedef logic [1:0] stride_mode_t;

  localparam stride_mode_t STRIDE_1   = 2'd0;
  localparam stride_mode_t STRIDE_2   = 2'd1;
  localparam stride_mode_t STRIDE_4   = 2'd2;
  // reserved encoding, never legal
  localparam stride_mode_t STRIDE_BAD = 2'd3;

endpackage

//--- logic/conv_sys_top.sv
`timescale 1ns/1ps

module conv_sys_top #(
  parameter int FMAP_WIDTH   = 7,
  parameter int FMAP_HEIGHT  = 7,
  parameter int OUT_CHANNELS = 2
) (
  input  logic                   clk,
  input  logic                   arst_n_in,
  input  logic                   start,
  input  conv_pkg::stride_mode_t stride_mode,
  input  conv_pkg::pixel_row_t   row,
  input  logic                   row_valid,
  output logic                   row_ready,
  output logic                   running,
  output logic                   out_valid,
  output conv_pkg::conv_result_t out_result
);

  import conv_pkg::*;

  // sequencer strobes per engine
  load_ctrl_t                  load_0;
  load_ctrl_t                  load_1;
  logic                        combine_en;
  // loop position and wrap flags
  coord_t                      pos;
  logic                        last_xy;
  logic                        last_all;
  // per engine dot products
  logic signed [ACC_WIDTH-1:0] sum_0;
  logic signed [ACC_WIDTH-1:0] sum_1;

  // counters step once per combined window
  loop_counters #(
    .FMAP_WIDTH  (FMAP_WIDTH),
    .FMAP_HEIGHT (FMAP_HEIGHT),
    .OUT_CHANNELS(OUT_CHANNELS)
  ) loop_counters_inst (
    .clk        (clk),
    .arst_n_in  (arst_n_in),
    .stride_mode(stride_mode),
    .start      (start),
    .step       (combine_en),
    .pos        (pos),
    .last_xy    (last_xy),
    .last_all   (last_all)
  );

  window_sequencer window_sequencer_inst (
    .clk       (clk),
    .arst_n_in (arst_n_in),
    .start     (start),
    .row_valid (row_valid),
    .last_xy   (last_xy),
    .last_all  (last_all),
    .row_ready (row_ready),
    .running   (running),
    .load_0    (load_0),
    .load_1    (load_1),
    .combine_en(combine_en)
  );

  // input channel 0
  window_mac engine_0 (
    .clk      (clk),
    .arst_n_in(arst_n_in),
    .row      (row),
    .load     (load_0),
    .sum      (sum_0)
  );

  // input channel 1, same row bus
  window_mac engine_1 (
    .clk      (clk),
    .arst_n_in(arst_n_in),
    .row      (row),
    .load     (load_1),
    .sum      (sum_1)
  );

  result_combiner result_combiner_inst (
    .clk       (clk),
    .arst_n_in (arst_n_in),
    .combine_en(combine_en),
    .sum_0     (sum_0),
    .sum_1     (sum_1),
    .pos       (pos),
    .out_valid (out_valid),
    .out_result(out_result)
  );

endmodule

//--- logic/loop_counters.sv
`timescale 1ns/1ps

module loop_counters #(
  parameter int FMAP_WIDTH   = 7,
  parameter int FMAP_HEIGHT  = 7,
  parameter int OUT_CHANNELS = 2
) (
  input  logic                 clk,
  input  logic                 arst_n_in,
  input  conv_pkg::stride_mode_t stride_mode,
  input  logic                 start,
  input  logic                 step,
  output conv_pkg::coord_t     pos,
  output logic                 last_xy,
  output logic                 last_all
);

  import conv_pkg::*;

  coord_t                 pos_q;
  stride_mode_t           stride_q;
  logic [COORD_WIDTH-1:0] stride_step;
  logic                   last_x;
  logic                   last_y;
  logic                   last_ch;

  // stride held for the whole run, sampled with start
  always_comb begin
    case (stride_q)
      STRIDE_2: stride_step = COORD_WIDTH'(2);
      STRIDE_4: stride_step = COORD_WIDTH'(4);
      default:  stride_step = COORD_WIDTH'(1);
    endcase
  end

  // last when the next window would run past the map edge
  assign last_y  = (int'(pos_q.y) + int'(stride_step) + KERNEL_SIZE) > FMAP_HEIGHT;
  assign last_x  = (int'(pos_q.x) + int'(stride_step) + KERNEL_SIZE) > FMAP_WIDTH;
  assign last_ch = int'(pos_q.ch) == OUT_CHANNELS - 1;

  assign last_xy  = last_x && last_y;
  assign last_all = last_xy && last_ch;
  assign pos      = pos_q;

  // y fastest, then x, then output channel
  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      pos_q    <= '0;
      stride_q <= STRIDE_1;
    end else if (start) begin
      pos_q    <= '0;
      stride_q <= stride_mode;
    end else if (step) begin
      if (last_y) begin
        pos_q.y <= '0;
        if (last_x) begin
          pos_q.x  <= '0;
          // wraps to 0 after the final channel
          pos_q.ch <= last_ch ? '0 : pos_q.ch + 1'b1;
        end else begin
          pos_q.x <= pos_q.x + stride_step;
        end
      end else begin
        pos_q.y <= pos_q.y + stride_step;
      end
    end
  end

  // reserved stride code must never start a run
  assert property (@(posedge clk) disable iff (!arst_n_in)
    start |-> (stride_mode != STRIDE_BAD));

endmodule

//--- logic/result_combiner.sv
`timescale 1ns/1ps

module result_combiner (
  input  logic                                  clk,
  input  logic                                  arst_n_in,
  input  logic                                  combine_en,
  input  logic signed [conv_pkg::ACC_WIDTH-1:0] sum_0,
  input  logic signed [conv_pkg::ACC_WIDTH-1:0] sum_1,
  input  conv_pkg::coord_t                      pos,
  output logic                                  out_valid,
  output conv_pkg::conv_result_t                out_result
);

  import conv_pkg::*;

  // sum over both input channels
  logic signed [ACC_WIDTH-1:0] pixel_sum;
  conv_result_t                result_q;
  logic                        valid_q;

  // headroom is ample, two 36-bit sums fit in 40 bits
  assign pixel_sum = sum_0 + sum_1;

  // output strobe one cycle behind combine_en
  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= combine_en;
    end
  end

  // value and tag captured together
  // pos is pre-advance, counters step on this same edge
  always_ff @(posedge clk) begin
    if (combine_en) begin
      result_q.value <= pixel_sum;
      result_q.pos   <= pos;
    end
  end

  // held until the next combine
  assign out_result = result_q;
  assign out_valid  = valid_q;

endmodule

//--- logic/window_mac.sv
`timescale 1ns/1ps

module window_mac (
  input  logic                                clk,
  input  logic                                arst_n_in,
  input  conv_pkg::pixel_row_t                row,
  input  conv_pkg::load_ctrl_t                load,
  output logic signed [conv_pkg::ACC_WIDTH-1:0] sum
);

  import conv_pkg::*;

  // kernel rows, reloaded once per output channel
  pixel_row_t wt_rows [KERNEL_SIZE];
  // input window rows, reloaded every window
  pixel_row_t in_rows [KERNEL_SIZE];

  logic signed [ACC_WIDTH-1:0] acc;

  // slot r of the strobe selects row r
  always_ff @(posedge clk) begin
    for (int r = 0; r < KERNEL_SIZE; r++) begin
      if (load.wt_we[r]) begin
        wt_rows[r] <= row;
      end
      if (load.in_we[r]) begin
        in_rows[r] <= row;
      end
    end
  end

  // nine signed products summed at full accumulator width
  always_comb begin
    acc = '0;
    for (int r = 0; r < KERNEL_SIZE; r++) begin
      for (int c = 0; c < KERNEL_SIZE; c++) begin
        // operands sign extended to ACC_WIDTH before the multiply
        acc = acc + (wt_rows[r][c] * in_rows[r][c]);
      end
    end
  end

  // valid the cycle after the last row write
  assign sum = acc;

  // only one row slot written per transfer
  assert property (@(posedge clk) disable iff (!arst_n_in)
    $onehot0(load));

endmodule

//--- logic/window_sequencer.sv
`timescale 1ns/1ps

module window_sequencer (
  input  logic                 clk,
  input  logic                 arst_n_in,
  input  logic                 start,
  input  logic                 row_valid,
  input  logic                 last_xy,
  input  logic                 last_all,
  output logic                 row_ready,
  output logic                 running,
  output conv_pkg::load_ctrl_t load_0,
  output conv_pkg::load_ctrl_t load_1,
  output logic                 combine_en
);

  import conv_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    WEIGHTS_0,
    WEIGHTS_1,
    INPUTS,
    COMBINE
  } seq_state_e;

  seq_state_e             state;
  seq_state_e             state_next;
  // row slot, 0..2 for weights, 0..5 for inputs
  logic [2:0]             slot;
  logic [2:0]             slot_next;
  logic [KERNEL_SIZE-1:0] row_sel;
  logic                   xfer;

  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      state <= IDLE;
      slot  <= '0;
    end else begin
      state <= state_next;
      slot  <= slot_next;
    end
  end

  // accept rows only while fetching, never in COMBINE
  assign row_ready  = (state == WEIGHTS_0) || (state == WEIGHTS_1) || (state == INPUTS);
  assign xfer       = row_valid && row_ready;
  assign running    = state != IDLE;
  assign combine_en = state == COMBINE;

  // slot to one-hot row select, slots 3..5 reuse rows 0..2
  always_comb begin
    case (slot)
      3'd0, 3'd3: row_sel = 3'b001;
      3'd1, 3'd4: row_sel = 3'b010;
      default:    row_sel = 3'b100;
    endcase
  end

  // write strobes, only in the cycle of a transfer
  always_comb begin
    load_0 = '0;
    load_1 = '0;
    case (state)
      WEIGHTS_0: load_0.wt_we = xfer ? row_sel : '0;
      WEIGHTS_1: load_1.wt_we = xfer ? row_sel : '0;
      INPUTS: begin
        // first three rows go to engine 0
        if (slot < 3'd3) begin
          load_0.in_we = xfer ? row_sel : '0;
        end else begin
          load_1.in_we = xfer ? row_sel : '0;
        end
      end
      default: ;
    endcase
  end

  always_comb begin
    state_next = state;
    slot_next  = slot;
    case (state)
      IDLE: begin
        if (start) begin
          state_next = WEIGHTS_0;
          slot_next  = '0;
        end
      end
      WEIGHTS_0: begin
        if (xfer) begin
          slot_next  = (slot == 3'd2) ? 3'd0 : slot + 3'd1;
          state_next = (slot == 3'd2) ? WEIGHTS_1 : WEIGHTS_0;
        end
      end
      WEIGHTS_1: begin
        if (xfer) begin
          slot_next  = (slot == 3'd2) ? 3'd0 : slot + 3'd1;
          state_next = (slot == 3'd2) ? INPUTS : WEIGHTS_1;
        end
      end
      INPUTS: begin
        // sixth row closes the window
        if (xfer) begin
          slot_next  = (slot == 3'd5) ? 3'd0 : slot + 3'd1;
          state_next = (slot == 3'd5) ? COMBINE : INPUTS;
        end
      end
      COMBINE: begin
        // flags still show the pre-advance position here
        if (last_all) begin
          state_next = IDLE;
        end else if (last_xy) begin
          state_next = WEIGHTS_0;
        end else begin
          state_next = INPUTS;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  // the shared row bus feeds one slot of one engine per transfer
  assert property (@(posedge clk) disable iff (!arst_n_in)
    $onehot0({load_0, load_1}) && ((|{load_0, load_1}) == xfer));

endmodule

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_conv_sys -f conv_sys.f \
  -o sim_conv_sys > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_conv_sys > sim.log 2>&1
cat sim.log
grep -q "SIMULATION PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

//--- tests/output_checker.sv
`timescale 1ns/1ps

module output_checker #(
  parameter int FMAP_WIDTH   = 7,
  parameter int FMAP_HEIGHT  = 7,
  parameter int OUT_CHANNELS = 2
) (
  input  logic                   clk,
  input  logic                   arst_n_in,
  input  logic                   start,
  input  conv_pkg::stride_mode_t stride_mode,
  input  conv_pkg::pixel_row_t   row,
  input  logic                   row_valid,
  input  logic                   row_ready,
  input  logic                   running,
  input  logic                   out_valid,
  input  conv_pkg::conv_result_t out_result,
  input  int                     test_index,
  input  int                     expected_count,
  output int                     error_count,
  output int                     result_total
);

  import conv_pkg::*;

  // mirrored rows, engine then row slot
  pixel_row_t   wt_m [2][KERNEL_SIZE];
  pixel_row_t   in_m [2][KERNEL_SIZE];
  // expected pixels and the cycle each is due
  conv_result_t exp_q [$];
  int           due_q [$];
  int           cycle = 0;
  int           errors = 0;
  int           results = 0;
  int           got = 0;
  int           test_errors = 0;
  int           slot = 0;
  int           step = 1;
  int           x = 0;
  int           y = 0;
  int           ch = 0;
  logic         active = 1'b0;
  logic         loading_wt = 1'b0;
  logic         running_q = 1'b0;

  assign error_count  = errors;
  assign result_total = results;

  task automatic report_error(input string msg);
    errors++;
    test_errors++;
    $display("%s", msg);
  endtask

  // both input channels, nine products each
  function automatic longint window_dot();
    longint total;
    total = 0;
    for (int e = 0; e < 2; e++) begin
      for (int r = 0; r < KERNEL_SIZE; r++) begin
        for (int c = 0; c < KERNEL_SIZE; c++) begin
          total += longint'($signed(wt_m[e][r][c])) * longint'($signed(in_m[e][r][c]));
        end
      end
    end
    return total;
  endfunction

  task automatic close_window();
    conv_result_t expected;
    expected.value  = ACC_WIDTH'(window_dot());
    expected.pos.x  = COORD_WIDTH'(x);
    expected.pos.y  = COORD_WIDTH'(y);
    expected.pos.ch = COORD_WIDTH'(ch);
    exp_q.push_back(expected);
    // combine next cycle, registered pixel one later
    due_q.push_back(cycle + 2);
    // y fastest, then x, then channel
    if (y + step + KERNEL_SIZE > FMAP_HEIGHT) begin
      y = 0;
      if (x + step + KERNEL_SIZE > FMAP_WIDTH) begin
        x = 0;
        // next channel starts with fresh kernels
        loading_wt = 1'b1;
        if (ch == OUT_CHANNELS - 1) begin
          active = 1'b0;
        end
        ch++;
      end else begin
        x += step;
      end
    end else begin
      y += step;
    end
  endtask

  task automatic take_row();
    // slots 0..2 engine 0, 3..5 engine 1
    if (loading_wt) begin
      wt_m[slot / KERNEL_SIZE][slot % KERNEL_SIZE] = row;
    end else begin
      in_m[slot / KERNEL_SIZE][slot % KERNEL_SIZE] = row;
    end
    slot++;
    if (slot == 2 * KERNEL_SIZE) begin
      slot = 0;
      if (loading_wt) begin
        loading_wt = 1'b0;
      end else begin
        close_window();
      end
    end
  endtask

  task automatic check_result();
    conv_result_t expected;
    int           due;
    logic         last;
    if (exp_q.size() == 0) begin
      report_error($sformatf("extra result at cycle %0d with no window pending", cycle));
    end else begin
      expected = exp_q.pop_front();
      due      = due_q.pop_front();
      results++;
      got++;
      if (out_result.value !== expected.value) begin
        report_error($sformatf("mismatch out_result.value: expected 0x%h, actual 0x%h",
                               expected.value, out_result.value));
      end
      if (out_result.pos !== expected.pos) begin
        report_error($sformatf("mismatch out_result.pos: expected 0x%h, actual 0x%h",
                               expected.pos, out_result.pos));
      end
      if (cycle != due) begin
        report_error($sformatf("result came at cycle %0d, two cycles after its window is %0d",
                               cycle, due));
      end
      // running drops together with the final pixel
      last = !active && (exp_q.size() == 0);
      if (running === last) begin
        report_error($sformatf("mismatch running: expected 0x%h, actual 0x%h", !last, running));
      end
    end
  endtask

  always @(posedge clk) begin
    cycle++;
    if (!arst_n_in) begin
      active = 1'b0;
      exp_q.delete();
      due_q.delete();
    end else begin
      if (out_valid) begin
        check_result();
      end
      // end of a run
      if (running_q && !running) begin
        if (exp_q.size() != 0) begin
          report_error($sformatf("%0d results missing when running fell", exp_q.size()));
        end
        if (got != expected_count) begin
          report_error($sformatf("got %0d results, the data file expects %0d",
                                 got, expected_count));
        end
        $display("test %0d: %0d results, %0d errors", test_index, got, test_errors);
      end
      if (start && !running) begin
        active     = 1'b1;
        loading_wt = 1'b1;
        slot       = 0;
        x          = 0;
        y          = 0;
        ch         = 0;
        step       = 1 << int'(stride_mode);
        got        = 0;
        test_errors = 0;
      end else if (row_valid && row_ready) begin
        if (!active) begin
          report_error("a row was accepted while no run was active");
        end else begin
          take_row();
        end
      end
    end
    running_q = running;
  end

endmodule

//--- tests/stimulus_input.txt
// stimulus for tb_conv_sys, one test per line, all values hex
// columns: stride mode (0 step 1, 1 step 2, 2 step 4), valid gap period (0 none), results
// gap-free runs first
0 0 32
1 0 12
2 0 8
// same streams again with valid dropped every few rows
0 5 32
1 3 12
2 1 8
0 7 32

//--- tests/tb_conv_sys.sv
`timescale 1ns/1ps

module tb_conv_sys;

  import conv_pkg::*;

  localparam int          FMAP_WIDTH   = 7;
  localparam int          FMAP_HEIGHT  = 7;
  localparam int          OUT_CHANNELS = 2;
  localparam int          MAX_TESTS    = 16;
  localparam logic [31:0] SEED         = 32'h47c9_7a89;

  logic         clk;
  logic         arst_n_in;
  logic         start;
  stride_mode_t stride_mode;
  pixel_row_t   row;
  logic         row_valid;
  logic         row_ready;
  logic         running;
  logic         out_valid;
  conv_result_t out_result;
  int           test_index;
  int           expected_count;
  int           checker_errors;
  int           result_total;
  int           tb_errors = 0;
  int           timeout_limit = 0;
  int           cycle_count = 0;
  // three words per test: stride mode, gap period, expected count
  logic [31:0]  stim_mem [3*MAX_TESTS];

  conv_sys_top #(
    .FMAP_WIDTH  (FMAP_WIDTH),
    .FMAP_HEIGHT (FMAP_HEIGHT),
    .OUT_CHANNELS(OUT_CHANNELS)
  ) conv_sys_top_inst (
    .clk        (clk),
    .arst_n_in  (arst_n_in),
    .start      (start),
    .stride_mode(stride_mode),
    .row        (row),
    .row_valid  (row_valid),
    .row_ready  (row_ready),
    .running    (running),
    .out_valid  (out_valid),
    .out_result (out_result)
  );

  output_checker #(
    .FMAP_WIDTH  (FMAP_WIDTH),
    .FMAP_HEIGHT (FMAP_HEIGHT),
    .OUT_CHANNELS(OUT_CHANNELS)
  ) output_checker_inst (
    .clk           (clk),
    .arst_n_in     (arst_n_in),
    .start         (start),
    .stride_mode   (stride_mode),
    .row           (row),
    .row_valid     (row_valid),
    .row_ready     (row_ready),
    .running       (running),
    .out_valid     (out_valid),
    .out_result    (out_result),
    .test_index    (test_index),
    .expected_count(expected_count),
    .error_count   (checker_errors),
    .result_total  (result_total)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_idle(input string when);
    @(negedge clk);
    if (row_ready || out_valid || running) begin
      tb_errors++;
      $display("DUT not idle %s: row_ready %0b, out_valid %0b, running %0b",
               when, row_ready, out_valid, running);
    end
  endtask

  // data held until a cycle with ready high
  task automatic send_row(input pixel_row_t data);
    logic accepted;
    row       = data;
    row_valid = 1'b1;
    accepted  = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = row_ready;
      next_cycle();
    end
  endtask

  task automatic run_test(input int idx, input stride_mode_t mode, input int gap,
                          input int count);
    int          rows;
    logic [31:0] lcg;
    pixel_row_t  data;
    // kernels per channel plus six rows per window
    rows           = (count + OUT_CHANNELS) * 2 * KERNEL_SIZE;
    // same stream for every test, so gap runs repeat the gap-free values
    lcg            = SEED;
    test_index     = idx;
    expected_count = count;
    // offered while idle, must not transfer
    row       = '1;
    row_valid = 1'b1;
    next_cycle();
    next_cycle();
    row_valid   = 1'b0;
    stride_mode = mode;
    start       = 1'b1;
    next_cycle();
    start = 1'b0;
    for (int sent = 0; sent < rows; sent++) begin
      if (gap != 0 && sent != 0 && sent % gap == 0) begin
        row_valid = 1'b0;
        next_cycle();
      end
      for (int k = 0; k < KERNEL_SIZE; k++) begin
        lcg     = lcg_next(lcg);
        data[k] = lcg[31:16];
      end
      send_row(data);
    end
    row_valid = 1'b0;
    @(negedge clk);
    while (running) begin
      @(negedge clk);
    end
  endtask

  initial begin
    int n_tests;
    int gap;
    int count;
    arst_n_in      = 1'b0;
    start          = 1'b0;
    stride_mode    = STRIDE_1;
    row            = '0;
    row_valid      = 1'b0;
    test_index     = 0;
    expected_count = 0;
    // all ones marks the end of the test list
    for (int i = 0; i < 3 * MAX_TESTS; i++) begin
      stim_mem[i] = '1;
    end
    $readmemh("tests/stimulus_input.txt", stim_mem);
    n_tests = 0;
    while (n_tests < MAX_TESTS && stim_mem[3 * n_tests] != '1) begin
      n_tests++;
    end
    // rows, doubled under gaps, plus combines and per test overhead
    timeout_limit = 20;
    for (int t = 0; t < n_tests; t++) begin
      gap   = int'(stim_mem[3 * t + 1]);
      count = int'(stim_mem[3 * t + 2]);
      timeout_limit += (count + OUT_CHANNELS) * 2 * KERNEL_SIZE * ((gap != 0) ? 2 : 1);
      timeout_limit += count + 16;
    end
    repeat (2) @(posedge clk);
    #1;
    arst_n_in = 1'b1;
    check_idle("after reset");
    if (n_tests == 0) begin
      tb_errors++;
      $display("no tests found in the stimulus file");
    end
    for (int t = 0; t < n_tests; t++) begin
      next_cycle();
      run_test(t, stim_mem[3 * t][1:0], int'(stim_mem[3 * t + 1]), int'(stim_mem[3 * t + 2]));
      check_idle("after the run");
    end
    $display("summary: %0d tests, %0d results, %0d checker errors, %0d testbench errors",
             n_tests, result_total, checker_errors, tb_errors);
    if (checker_errors + tb_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // hang guard
  initial begin
    wait (timeout_limit != 0);
    while (cycle_count < timeout_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", cycle_count);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule
